// File: source/dsp_types_pkg.sv
package dsp_types_pkg;

	// The core has a file of 16 signed data channels
	localparam int n_channels = 16;

	typedef logic [3 : 0] channel_addr_t;
	typedef logic [4 : 0] opcode_t;
	typedef logic [5 : 0] commit_id_t;

	// With src_reg set, src is a register or constant code instead of a channel
	typedef struct packed {
		logic [3 : 0] src;
		logic         src_reg;
		logic         needed;
	} operand_spec_t;

	typedef struct packed {
		opcode_t       opcode;
		channel_addr_t dest;
		logic          writes_channel;
		operand_spec_t op_a;
		operand_spec_t op_b;
		operand_spec_t op_c;
	} fetch_instr_t;

	// Write data goes beside this struct since its width is a module parameter
	typedef struct packed {
		logic          enable;
		channel_addr_t addr;
	} channel_write_t;

endpackage

// File: source/fetch_ctrl_pkg.sv
package fetch_ctrl_pkg;

	typedef enum logic {
		slot_idle,
		slot_stalled
	} slot_state_e;

	typedef enum logic [1 : 0] {
		slot_a,
		slot_b,
		slot_c
	} operand_slot_e;

	// Codes for operands that take a register or a constant
	localparam logic [3 : 0] src_register_0 = 4'd0;
	localparam logic [3 : 0] src_register_1 = 4'd1;
	// One quarter of full scale
	localparam logic [3 : 0] src_quarter_scale = 4'd3;
	localparam logic [3 : 0] src_most_negative = 4'd4;

endpackage

// File: source/channel_file.sv
`timescale 1ns/1ns

module channel_file #(
	parameter int data_width = 16
) (
	input  logic clk,
	input  logic reset,

	input  dsp_types_pkg::channel_write_t ch_write,
	input  logic signed [data_width - 1 : 0] ch_write_data,

	input  dsp_types_pkg::channel_addr_t rd_addr_a,
	input  dsp_types_pkg::channel_addr_t rd_addr_b,
	input  dsp_types_pkg::channel_addr_t rd_addr_c,

	output logic signed [data_width - 1 : 0] rd_data_a,
	output logic signed [data_width - 1 : 0] rd_data_b,
	output logic signed [data_width - 1 : 0] rd_data_c
);

	logic signed [data_width - 1 : 0] channels [dsp_types_pkg::n_channels];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dsp_types_pkg::n_channels; i++) begin
				channels[i] <= '0;
			end
		end else if (ch_write.enable) begin
			channels[ch_write.addr] <= ch_write_data;
		end
	end

	// A read in the same cycle as a write still sees the old value
	assign rd_data_a = channels[rd_addr_a];
	assign rd_data_b = channels[rd_addr_b];
	assign rd_data_c = channels[rd_addr_c];

endmodule

// File: source/channel_scoreboard.sv
`timescale 1ns/1ns

module channel_scoreboard (
	input  logic clk,
	input  logic reset,

	input  logic issue,
	input  dsp_types_pkg::channel_addr_t issue_dest,

	input  dsp_types_pkg::channel_write_t ch_write,

	input  dsp_types_pkg::channel_addr_t query_addr,
	output logic pending,
	output logic pending_one
);

	typedef logic [3 : 0] pending_count_t;

	pending_count_t counts [dsp_types_pkg::n_channels];

	logic [dsp_types_pkg::n_channels - 1 : 0] rise;
	logic [dsp_types_pkg::n_channels - 1 : 0] fall;

	always_comb begin
		for (int i = 0; i < dsp_types_pkg::n_channels; i++) begin
			rise[i] = issue && (issue_dest == dsp_types_pkg::channel_addr_t'(i));
			// A write nobody waits for leaves the count at zero
			fall[i] = ch_write.enable
				&& (ch_write.addr == dsp_types_pkg::channel_addr_t'(i))
				&& (counts[i] != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dsp_types_pkg::n_channels; i++) begin
				counts[i] <= '0;
			end
		end else begin
			for (int i = 0; i < dsp_types_pkg::n_channels; i++) begin
				case ({rise[i], fall[i]})
					2'b10: begin
						counts[i] <= counts[i] + 1'b1;
					end
					2'b01: begin
						counts[i] <= counts[i] - 1'b1;
					end
					default: begin
						counts[i] <= counts[i];
					end
				endcase
			end
		end
	end

	assign pending = (counts[query_addr] != '0);
	assign pending_one = (counts[query_addr] == pending_count_t'(1));

endmodule

// File: source/operand_fetch_slot.sv
`timescale 1ns/1ns

module operand_fetch_slot #(
	parameter int data_width = 16,
	parameter fetch_ctrl_pkg::operand_slot_e slot = fetch_ctrl_pkg::slot_a
) (
	input  logic clk,
	input  logic reset,

	input  logic in_valid,
	output logic in_ready,
	input  dsp_types_pkg::fetch_instr_t in_instr,
	input  logic signed [data_width - 1 : 0] in_reg_0,
	input  logic signed [data_width - 1 : 0] in_reg_1,
	input  logic signed [data_width - 1 : 0] in_arg_a,
	input  logic signed [data_width - 1 : 0] in_arg_b,

	output logic out_valid,
	input  logic out_ready,
	output dsp_types_pkg::fetch_instr_t out_instr,
	output logic signed [data_width - 1 : 0] out_reg_0,
	output logic signed [data_width - 1 : 0] out_reg_1,
	output logic signed [data_width - 1 : 0] out_arg_a,
	output logic signed [data_width - 1 : 0] out_arg_b,
	output logic signed [data_width - 1 : 0] out_arg_c,

	input  dsp_types_pkg::channel_write_t ch_write,
	input  logic signed [data_width - 1 : 0] ch_write_data,

	output dsp_types_pkg::channel_addr_t rd_addr,
	input  logic signed [data_width - 1 : 0] rd_data
);

	fetch_ctrl_pkg::slot_state_e state;

	dsp_types_pkg::fetch_instr_t held_instr;
	logic signed [data_width - 1 : 0] held_reg_0;
	logic signed [data_width - 1 : 0] held_reg_1;
	logic signed [data_width - 1 : 0] held_arg_a;
	logic signed [data_width - 1 : 0] held_arg_b;

	dsp_types_pkg::fetch_instr_t live_instr;
	logic signed [data_width - 1 : 0] live_reg_0;
	logic signed [data_width - 1 : 0] live_reg_1;
	logic signed [data_width - 1 : 0] live_arg_a;
	logic signed [data_width - 1 : 0] live_arg_b;

	dsp_types_pkg::operand_spec_t spec;
	logic signed [data_width - 1 : 0] reg_value;
	logic signed [data_width - 1 : 0] value;

	logic pending;
	logic pending_one;
	logic forward_hit;
	logic resolved;
	logic stalled;
	logic out_free;
	logic take_in;
	logic send;

	assign stalled = (state == fetch_ctrl_pkg::slot_stalled);

	// While stalled, the latched copy stands in for the input
	assign live_instr = stalled ? held_instr : in_instr;
	assign live_reg_0 = stalled ? held_reg_0 : in_reg_0;
	assign live_reg_1 = stalled ? held_reg_1 : in_reg_1;
	assign live_arg_a = stalled ? held_arg_a : in_arg_a;
	assign live_arg_b = stalled ? held_arg_b : in_arg_b;

	always_comb begin
		case (slot)
			fetch_ctrl_pkg::slot_a: spec = live_instr.op_a;
			fetch_ctrl_pkg::slot_b: spec = live_instr.op_b;
			default: spec = live_instr.op_c;
		endcase
	end

	assign rd_addr = spec.src;

	// Register and constant table, shared by the fresh and the stalled path
	always_comb begin
		reg_value = '0;
		case (spec.src)
			fetch_ctrl_pkg::src_register_0: reg_value = live_reg_0;
			fetch_ctrl_pkg::src_register_1: reg_value = live_reg_1;
			fetch_ctrl_pkg::src_quarter_scale: reg_value[data_width - 2] = 1'b1;
			fetch_ctrl_pkg::src_most_negative: reg_value[data_width - 1] = 1'b1;
			default: reg_value = '0;
		endcase
	end

	// The last outstanding write is arriving right now, so take it off the port
	assign forward_hit = pending_one && ch_write.enable && (ch_write.addr == spec.src);

	always_comb begin
		resolved = 1'b1;
		value = '0;
		if (!spec.needed) begin
			value = '0;
		end else if (spec.src_reg) begin
			value = reg_value;
		end else if (!pending) begin
			value = rd_data;
		end else if (forward_hit) begin
			value = ch_write_data;
		end else begin
			resolved = 1'b0;
		end
	end

	assign out_free = !out_valid || out_ready;
	assign in_ready = !stalled && out_free;
	assign take_in = in_valid && in_ready;
	assign send = (take_in || stalled) && resolved && out_free;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetch_ctrl_pkg::slot_idle;
			out_valid <= 1'b0;
		end else if (send) begin
			state <= fetch_ctrl_pkg::slot_idle;
			out_valid <= 1'b1;
		end else begin
			if (take_in)
				state <= fetch_ctrl_pkg::slot_stalled;
			if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			held_instr <= in_instr;
			held_reg_0 <= in_reg_0;
			held_reg_1 <= in_reg_1;
			held_arg_a <= in_arg_a;
			held_arg_b <= in_arg_b;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			out_instr <= live_instr;
			out_reg_0 <= live_reg_0;
			out_reg_1 <= live_reg_1;
			out_arg_a <= (slot == fetch_ctrl_pkg::slot_a) ? value : live_arg_a;
			out_arg_b <= (slot == fetch_ctrl_pkg::slot_b) ? value : live_arg_b;
			out_arg_c <= (slot == fetch_ctrl_pkg::slot_c) ? value : '0;
		end
	end

	// A write is counted as soon as the writer is loaded into the output register,
	// so a reader directly behind it already sees the pending count
	channel_scoreboard scoreboard_i (
		.clk(clk),
		.reset(reset),
		.issue(send && live_instr.writes_channel),
		.issue_dest(live_instr.dest),
		.ch_write(ch_write),
		.query_addr(spec.src),
		.pending(pending),
		.pending_one(pending_one)
	);

endmodule

// File: source/skid_buffer.sv
`timescale 1ns/1ns

module skid_buffer #(
	parameter int payload_width = 32
) (
	input  logic clk,
	input  logic reset,

	input  logic in_valid,
	output logic in_ready,
	input  logic [payload_width - 1 : 0] payload_in,

	output logic out_valid,
	input  logic out_ready,
	output logic [payload_width - 1 : 0] payload_out
);

	logic main_valid;
	logic skid_valid;
	logic [payload_width - 1 : 0] main_data;
	logic [payload_width - 1 : 0] skid_data;

	logic take_in;
	logic take_out;

	// Ready comes straight from a flop, so the downstream ready never reaches upstream
	assign in_ready = !skid_valid;
	assign out_valid = main_valid;
	assign payload_out = main_data;

	assign take_in = in_valid && in_ready;
	assign take_out = main_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (skid_valid) begin
			if (take_out) begin
				main_valid <= 1'b1;
				skid_valid <= 1'b0;
			end
		end else if (take_in) begin
			if (!main_valid || take_out)
				main_valid <= 1'b1;
			else
				skid_valid <= 1'b1;
		end else if (take_out) begin
			main_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (skid_valid && take_out)
			main_data <= skid_data;
		else if (take_in && (!main_valid || take_out))
			main_data <= payload_in;
		if (take_in && main_valid && !take_out)
			skid_data <= payload_in;
	end

endmodule

// File: source/operand_fetch_stage.sv
`timescale 1ns/1ns

module operand_fetch_stage #(
	parameter int data_width = 16
) (
	input  logic clk,
	input  logic reset,

	input  logic in_valid,
	output logic in_ready,
	input  dsp_types_pkg::fetch_instr_t in_instr,
	input  logic signed [data_width - 1 : 0] in_reg_0,
	input  logic signed [data_width - 1 : 0] in_reg_1,

	input  dsp_types_pkg::channel_write_t ch_write,
	input  logic signed [data_width - 1 : 0] ch_write_data,

	output logic out_valid,
	input  logic out_ready,
	output dsp_types_pkg::fetch_instr_t out_instr,
	output logic signed [data_width - 1 : 0] out_arg_a,
	output logic signed [data_width - 1 : 0] out_arg_b,
	output logic signed [data_width - 1 : 0] out_arg_c,
	output dsp_types_pkg::commit_id_t out_commit_id
);

	typedef struct packed {
		dsp_types_pkg::fetch_instr_t instr;
		logic signed [data_width - 1 : 0] arg_a;
		logic signed [data_width - 1 : 0] arg_b;
		logic signed [data_width - 1 : 0] arg_c;
		dsp_types_pkg::commit_id_t commit_id;
	} fetch_result_t;

	localparam int payload_width = $bits(fetch_result_t);

	logic a_valid;
	logic a_ready;
	dsp_types_pkg::fetch_instr_t a_instr;
	logic signed [data_width - 1 : 0] a_reg_0;
	logic signed [data_width - 1 : 0] a_reg_1;
	logic signed [data_width - 1 : 0] a_arg_a;
	logic signed [data_width - 1 : 0] a_arg_b;

	logic b_valid;
	logic b_ready;
	dsp_types_pkg::fetch_instr_t b_instr;
	logic signed [data_width - 1 : 0] b_reg_0;
	logic signed [data_width - 1 : 0] b_reg_1;
	logic signed [data_width - 1 : 0] b_arg_a;
	logic signed [data_width - 1 : 0] b_arg_b;

	logic c_valid;
	logic c_ready;
	dsp_types_pkg::fetch_instr_t c_instr;
	logic signed [data_width - 1 : 0] c_arg_a;
	logic signed [data_width - 1 : 0] c_arg_b;
	logic signed [data_width - 1 : 0] c_arg_c;

	dsp_types_pkg::channel_addr_t rd_addr_a;
	dsp_types_pkg::channel_addr_t rd_addr_b;
	dsp_types_pkg::channel_addr_t rd_addr_c;
	logic signed [data_width - 1 : 0] rd_data_a;
	logic signed [data_width - 1 : 0] rd_data_b;
	logic signed [data_width - 1 : 0] rd_data_c;

	dsp_types_pkg::commit_id_t commit_count;
	fetch_result_t skid_in;
	fetch_result_t skid_out;

	channel_file #(.data_width(data_width)) channel_file_i (
		.clk(clk),
		.reset(reset),
		.ch_write(ch_write),
		.ch_write_data(ch_write_data),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_addr_c(rd_addr_c),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.rd_data_c(rd_data_c)
	);

	operand_fetch_slot #(.data_width(data_width), .slot(fetch_ctrl_pkg::slot_a)) slot_a_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.in_reg_0(in_reg_0),
		.in_reg_1(in_reg_1),
		.in_arg_a('0),
		.in_arg_b('0),
		.out_valid(a_valid),
		.out_ready(a_ready),
		.out_instr(a_instr),
		.out_reg_0(a_reg_0),
		.out_reg_1(a_reg_1),
		.out_arg_a(a_arg_a),
		.out_arg_b(a_arg_b),
		.out_arg_c(),
		.ch_write(ch_write),
		.ch_write_data(ch_write_data),
		.rd_addr(rd_addr_a),
		.rd_data(rd_data_a)
	);

	operand_fetch_slot #(.data_width(data_width), .slot(fetch_ctrl_pkg::slot_b)) slot_b_i (
		.clk(clk),
		.reset(reset),
		.in_valid(a_valid),
		.in_ready(a_ready),
		.in_instr(a_instr),
		.in_reg_0(a_reg_0),
		.in_reg_1(a_reg_1),
		.in_arg_a(a_arg_a),
		.in_arg_b(a_arg_b),
		.out_valid(b_valid),
		.out_ready(b_ready),
		.out_instr(b_instr),
		.out_reg_0(b_reg_0),
		.out_reg_1(b_reg_1),
		.out_arg_a(b_arg_a),
		.out_arg_b(b_arg_b),
		.out_arg_c(),
		.ch_write(ch_write),
		.ch_write_data(ch_write_data),
		.rd_addr(rd_addr_b),
		.rd_data(rd_data_b)
	);

	operand_fetch_slot #(.data_width(data_width), .slot(fetch_ctrl_pkg::slot_c)) slot_c_i (
		.clk(clk),
		.reset(reset),
		.in_valid(b_valid),
		.in_ready(b_ready),
		.in_instr(b_instr),
		.in_reg_0(b_reg_0),
		.in_reg_1(b_reg_1),
		.in_arg_a(b_arg_a),
		.in_arg_b(b_arg_b),
		.out_valid(c_valid),
		.out_ready(c_ready),
		.out_instr(c_instr),
		.out_reg_0(),
		.out_reg_1(),
		.out_arg_a(c_arg_a),
		.out_arg_b(c_arg_b),
		.out_arg_c(c_arg_c),
		.ch_write(ch_write),
		.ch_write_data(ch_write_data),
		.rd_addr(rd_addr_c),
		.rd_data(rd_data_c)
	);

	// Channel writers are numbered in the order they leave the last slot
	always_ff @(posedge clk) begin
		if (reset)
			commit_count <= '0;
		else if (c_valid && c_ready && c_instr.writes_channel)
			commit_count <= commit_count + 1'b1;
	end

	// The register values end at the last slot and do not enter the payload
	always_comb begin
		skid_in.instr = c_instr;
		skid_in.arg_a = c_arg_a;
		skid_in.arg_b = c_arg_b;
		skid_in.arg_c = c_arg_c;
		skid_in.commit_id = commit_count;
	end

	skid_buffer #(.payload_width(payload_width)) skid_buffer_i (
		.clk(clk),
		.reset(reset),
		.in_valid(c_valid),
		.in_ready(c_ready),
		.payload_in(skid_in),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.payload_out(skid_out)
	);

	assign out_instr = skid_out.instr;
	assign out_arg_a = skid_out.arg_a;
	assign out_arg_b = skid_out.arg_b;
	assign out_arg_c = skid_out.arg_c;
	assign out_commit_id = skid_out.commit_id;

endmodule

// File: sim/fetch_tb_tasks.svh
task automatic check_value(string what, logic signed [127 : 0] actual,
		logic signed [127 : 0] expected);
	if (actual !== expected) begin
		$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		$display("Some tests failed");
		$fatal(1, "Check failed");
	end
endtask

function automatic dsp_types_pkg::operand_spec_t spec_of(logic [3 : 0] src, logic src_reg,
		logic needed);
	dsp_types_pkg::operand_spec_t spec;
	spec.src = src;
	spec.src_reg = src_reg;
	spec.needed = needed;
	return spec;
endfunction

function automatic dsp_types_pkg::fetch_instr_t directed_instr(
		dsp_types_pkg::operand_spec_t a, dsp_types_pkg::operand_spec_t b,
		dsp_types_pkg::operand_spec_t c);
	dsp_types_pkg::fetch_instr_t instr;
	instr.opcode = dsp_types_pkg::opcode_t'($urandom);
	instr.dest = '0;
	instr.writes_channel = 1'b0;
	instr.op_a = a;
	instr.op_b = b;
	instr.op_c = c;
	return instr;
endfunction

// Channels 12 to 15 are only ever written, so random readers never wait
function automatic dsp_types_pkg::operand_spec_t mixed_operand();
	int kind;
	kind = $urandom % 4;
	if (kind == 1)
		return spec_of(4'($urandom % 8), 1'b1, 1'b1);
	return spec_of(4'($urandom % 12), 1'b0, kind != 0);
endfunction

function automatic dsp_types_pkg::fetch_instr_t random_instr();
	dsp_types_pkg::fetch_instr_t instr;
	instr = directed_instr(mixed_operand(), mixed_operand(), mixed_operand());
	instr.dest = 4'(12 + ($urandom % 4));
	instr.writes_channel = 1'($urandom % 2);
	return instr;
endfunction

function automatic data_t operand_model(dsp_types_pkg::operand_spec_t spec, data_t reg_0,
		data_t reg_1);
	if (!spec.needed)
		return '0;
	if (!spec.src_reg)
		return channel_model[spec.src];
	case (spec.src)
		4'd0: return reg_0;
		4'd1: return reg_1;
		4'd3: return data_t'(16384);
		4'd4: return data_t'(-32768);
		default: return '0;
	endcase
endfunction

function automatic result_t capture_output();
	result_t r;
	r.instr = out_instr;
	r.arg_a = out_arg_a;
	r.arg_b = out_arg_b;
	r.arg_c = out_arg_c;
	r.is_writer = out_instr.writes_channel;
	r.commit_id = out_commit_id;
	return r;
endfunction

task automatic push_expected(dsp_types_pkg::fetch_instr_t instr, data_t reg_0, data_t reg_1);
	result_t r;
	r.instr = instr;
	r.arg_a = operand_model(instr.op_a, reg_0, reg_1);
	r.arg_b = operand_model(instr.op_b, reg_0, reg_1);
	r.arg_c = operand_model(instr.op_c, reg_0, reg_1);
	r.is_writer = instr.writes_channel;
	r.commit_id = dsp_types_pkg::commit_id_t'(next_commit);
	if (instr.writes_channel) begin
		next_commit++;
		pending_model[instr.dest]++;
	end
	expected_q.push_back(r);
endtask

// Called and left one ns after a rising edge
task automatic send_instr(dsp_types_pkg::fetch_instr_t instr, data_t reg_0, data_t reg_1);
	logic accepted;
	in_valid = 1'b1;
	in_instr = instr;
	in_reg_0 = reg_0;
	in_reg_1 = reg_1;
	do begin
		@(negedge clk);
		accepted = in_ready;
		@(posedge clk);
		#1;
	end while (!accepted);
	in_valid = 1'b0;
endtask

task automatic issue_instr(dsp_types_pkg::fetch_instr_t instr, data_t reg_0, data_t reg_1);
	push_expected(instr, reg_0, reg_1);
	send_instr(instr, reg_0, reg_1);
endtask

task automatic write_channel(dsp_types_pkg::channel_addr_t addr, data_t data);
	ch_write.enable = 1'b1;
	ch_write.addr = addr;
	ch_write_data = data;
	channel_model[addr] = data;
	if (pending_model[addr] > 0)
		pending_model[addr]--;
	@(posedge clk);
	#1;
	ch_write.enable = 1'b0;
endtask

// Settles every write the scoreboards still wait for, keeping the data as it is
task automatic drain_pending();
	for (int i = 0; i < dsp_types_pkg::n_channels; i++) begin
		while (pending_model[i] > 0)
			write_channel(4'(i), channel_model[i]);
	end
endtask

task automatic receive_results(int count);
	result_t exp;
	result_t got;
	int received;
	received = 0;
	while (received < count) begin
		@(negedge clk);
		if (out_valid && out_ready) begin
			if (expected_q.size() == 0) begin
				$display("The DUT delivered an output that matches no instruction sent");
				$display("Some tests failed");
				$fatal(1, "Unexpected output");
			end else begin
				exp = expected_q.pop_front();
				got = capture_output();
				check_value("out_instr", got.instr, exp.instr);
				check_value("out_arg_a", got.arg_a, exp.arg_a);
				check_value("out_arg_b", got.arg_b, exp.arg_b);
				check_value("out_arg_c", got.arg_c, exp.arg_c);
				if (exp.is_writer)
					check_value("out_commit_id", got.commit_id, exp.commit_id);
				received++;
			end
		end
	end
	@(posedge clk);
	#1;
endtask

task automatic hold_output(int cycles, output logic saw_in_ready_low);
	result_t held;
	logic held_seen;
	held_seen = 1'b0;
	saw_in_ready_low = 1'b0;
	out_ready = 1'b0;
	repeat (cycles) begin
		@(negedge clk);
		if (!in_ready)
			saw_in_ready_low = 1'b1;
		if (held_seen) begin
			check_value("out_valid while held", out_valid, 1);
			check_value("payload while held", capture_output(), held);
		end else if (out_valid) begin
			held = capture_output();
			held_seen = 1'b1;
		end
	end
	@(posedge clk);
	#1;
	out_ready = 1'b1;
endtask

task automatic zero_channels_after_reset();
	@(negedge clk);
	check_value("out_valid after reset", out_valid, 0);
	@(posedge clk);
	#1;
	fork
		for (int i = 0; i < dsp_types_pkg::n_channels; i++) begin
			issue_instr(directed_instr(spec_of(4'(i), 1'b0, 1'b1),
				spec_of(4'((i + 5) % 16), 1'b0, 1'b1),
				spec_of(4'((i + 10) % 16), 1'b0, 1'b1)), data_t'($urandom), data_t'($urandom));
		end
		receive_results(dsp_types_pkg::n_channels);
	join
endtask

task automatic register_and_constant_sources();
	fork
		begin
			issue_instr(directed_instr(spec_of(4'd0, 1'b1, 1'b1), spec_of(4'd1, 1'b1, 1'b1),
				spec_of(4'd3, 1'b1, 1'b1)), data_t'($urandom), data_t'($urandom));
			issue_instr(directed_instr(spec_of(4'd4, 1'b1, 1'b1), spec_of(4'd7, 1'b1, 1'b1),
				spec_of(4'd0, 1'b1, 1'b0)), data_t'($urandom), data_t'($urandom));
			issue_instr(directed_instr(spec_of(4'd3, 1'b1, 1'b0), spec_of(4'd1, 1'b1, 1'b1),
				spec_of(4'd9, 1'b0, 1'b0)), data_t'($urandom), data_t'($urandom));
		end
		receive_results(3);
	join
endtask

task automatic plain_channel_reads();
	for (int i = 0; i < 12; i++)
		write_channel(4'(i), data_t'($urandom));
	fork
		repeat (8) begin
			issue_instr(directed_instr(spec_of(4'($urandom % 12), 1'b0, 1'b1),
				spec_of(4'($urandom % 12), 1'b0, 1'b1),
				spec_of(4'($urandom % 12), 1'b0, 1'b1)), data_t'($urandom), data_t'($urandom));
		end
		receive_results(8);
	join
endtask

task automatic read_after_write_stall();
	dsp_types_pkg::fetch_instr_t writer;
	dsp_types_pkg::fetch_instr_t reader;
	writer = directed_instr(spec_of(4'd0, 1'b0, 1'b0), spec_of(4'd0, 1'b0, 1'b0),
		spec_of(4'd0, 1'b0, 1'b0));
	writer.dest = 4'd5;
	writer.writes_channel = 1'b1;
	reader = directed_instr(spec_of(4'd0, 1'b0, 1'b0), spec_of(4'd5, 1'b0, 1'b1),
		spec_of(4'd0, 1'b0, 1'b0));
	fork
		begin
			issue_instr(writer, '0, '0);
			send_instr(reader, '0, '0);
		end
		receive_results(1);
	join
	// The reader sits in slot b until the owed write to channel 5 shows up
	repeat (20) begin
		@(negedge clk);
		check_value("out_valid while reader waits on channel 5", out_valid, 0);
	end
	@(posedge clk);
	#1;
	write_channel(4'd5, data_t'($urandom));
	push_expected(reader, '0, '0);
	receive_results(1);
endtask

task automatic order_and_commit_ids();
	fork
		repeat (20) begin
			issue_instr(random_instr(), data_t'($urandom), data_t'($urandom));
		end
		receive_results(20);
	join
	drain_pending();
endtask

task automatic back_pressure_hold();
	logic saw_in_ready_low;
	out_ready = 1'b0;
	fork
		repeat (10) begin
			issue_instr(random_instr(), data_t'($urandom), data_t'($urandom));
		end
		begin
			hold_output(25, saw_in_ready_low);
			receive_results(10);
		end
	join
	check_value("in_ready dropped under back-pressure", saw_in_ready_low, 1);
	// Every instruction has come out once, so the output stays empty
	repeat (4) begin
		@(negedge clk);
		check_value("out_valid after the last result", out_valid, 0);
	end
	@(posedge clk);
	#1;
	drain_pending();
endtask

// File: sim/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

	localparam int data_width = 16;
	localparam int max_cycles = 2000;

	typedef logic signed [data_width - 1 : 0] data_t;

	// One output word as the DUT must deliver it
	typedef struct packed {
		dsp_types_pkg::fetch_instr_t instr;
		data_t arg_a;
		data_t arg_b;
		data_t arg_c;
		logic is_writer;
		dsp_types_pkg::commit_id_t commit_id;
	} result_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	dsp_types_pkg::fetch_instr_t in_instr;
	data_t in_reg_0;
	data_t in_reg_1;
	dsp_types_pkg::channel_write_t ch_write;
	data_t ch_write_data;
	logic out_valid;
	logic out_ready;
	dsp_types_pkg::fetch_instr_t out_instr;
	data_t out_arg_a;
	data_t out_arg_b;
	data_t out_arg_c;
	dsp_types_pkg::commit_id_t out_commit_id;

	// Reference copy of the channels, and the writes still owed to each channel
	data_t channel_model [dsp_types_pkg::n_channels];
	int pending_model [dsp_types_pkg::n_channels];
	int next_commit;
	result_t expected_q [$];
	int cycle_count = 0;

	`include "fetch_tb_tasks.svh"

	operand_fetch_stage #(.data_width(data_width)) dut_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.in_reg_0(in_reg_0),
		.in_reg_1(in_reg_1),
		.ch_write(ch_write),
		.ch_write_data(ch_write_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_instr(out_instr),
		.out_arg_a(out_arg_a),
		.out_arg_b(out_arg_b),
		.out_arg_c(out_arg_c),
		.out_commit_id(out_commit_id)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("Some tests failed");
			$fatal(1, "Run aborted by timeout");
		end
	end

	initial begin
		void'($urandom(33));
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		in_reg_0 = '0;
		in_reg_1 = '0;
		ch_write = '0;
		ch_write_data = '0;
		out_ready = 1'b1;
		next_commit = 0;
		for (int i = 0; i < dsp_types_pkg::n_channels; i++) begin
			channel_model[i] = '0;
			pending_model[i] = 0;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		zero_channels_after_reset();
		register_and_constant_sources();
		plain_channel_reads();
		read_after_write_stall();
		order_and_commit_ids();
		back_pressure_hold();

		$display("All tests passed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+sim
source/dsp_types_pkg.sv
source/fetch_ctrl_pkg.sv
source/channel_file.sv
source/channel_scoreboard.sv
source/operand_fetch_slot.sv
source/skid_buffer.sv
source/operand_fetch_stage.sv
sim/fetch_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := fetch_tb
FLIST     := flist.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard source/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
